// ==== fetch_config.svh ====
// fetch front end parameters
// FIFO sizing, AXI burst shape, bus widths and the idle instruction word

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// --------------------------------------------------
// fifo
`define FETCH_FIFO_DEPTH 16
`define FETCH_PTR_W      4
`define FETCH_CNT_W      5

// --------------------------------------------------
// axi read bus
`define FETCH_BURST_LEN  4
`define FETCH_ADDR_W     32
`define FETCH_DATA_W     64
`define FETCH_ID_W       4

// shown on the output when no instruction is ready
`define FETCH_NOP        32'h13

`endif

// ==== fetch_pkg.sv ====
// fetch front end types
// AXI read channel structs, FIFO row view and instruction output

`include "fetch_config.svh"

package fetch_pkg;

  localparam logic [1:0] burst_incr = 2'b01;

  // --------------------------------------------------
  // axi read address channel
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] araddr;
    logic [7:0]               arlen;
    logic [2:0]               arsize;
    logic [1:0]               arburst;
    logic                     arvalid;
  } axi_ar_t;

  // axi read data channel
  typedef struct packed {
    logic [`FETCH_DATA_W-1:0] rdata;
    logic [1:0]               rresp;
    logic                     rlast;
    logic                     rvalid;
  } axi_r_t;

  // one fifo row, whole beat or four parcels
  // parcel 0 sits at the lowest address
  typedef union packed {
    logic [`FETCH_DATA_W-1:0] dword;
    logic [3:0][15:0]         parcel;
  } fetch_row_u;

  // --------------------------------------------------
  // aligned instruction towards the core
  typedef struct packed {
    logic [31:0]              instr;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     compressed;
  } instr_out_t;

endpackage

// ==== fetch_fifo.sv ====
// fetch row FIFO
// circular buffer of 64-bit beats between the bus master and the aligner

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_fifo (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         clear,
  input  logic                         wr_en,
  input  fetch_pkg::fetch_row_u        din,
  input  logic                         rd_en,
  output fetch_pkg::fetch_row_u        dout,
  output logic                         full,
  output logic                         empty,
  output logic [`FETCH_CNT_W-1:0]      free_rows
);

  localparam logic [`FETCH_CNT_W-1:0] depth_rows = `FETCH_FIFO_DEPTH;

  fetch_pkg::fetch_row_u mem [`FETCH_FIFO_DEPTH];

  logic [`FETCH_PTR_W-1:0] wr_ptr;
  logic [`FETCH_PTR_W-1:0] rd_ptr;
  logic [`FETCH_CNT_W-1:0] count;
  logic                    do_wr;
  logic                    do_rd;

  assign do_wr     = wr_en && !full;
  assign do_rd     = rd_en && !empty;
  assign full      = (count == depth_rows);
  assign empty     = (count == '0);
  assign free_rows = depth_rows - count;

  // head row visible without a read latency
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr && !clear) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

// ==== ifu_mem_ctrl.sv ====
// instruction memory read master
// sequential AXI INCR bursts into the fetch FIFO, stale beats dropped on redirect

`timescale 1ns/1ps
`include "fetch_config.svh"

module ifu_mem_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect,
  input  logic [`FETCH_ADDR_W-1:0]     redirect_pc,
  output fetch_pkg::axi_ar_t           ar,
  input  logic                         arready,
  input  fetch_pkg::axi_r_t            r,
  output logic                         rready,
  output logic                         fifo_wr,
  output fetch_pkg::fetch_row_u        fifo_din,
  output logic                         fifo_clear,
  input  logic [`FETCH_CNT_W-1:0]      free_rows,
  input  logic                         full
);

  localparam logic [`FETCH_ADDR_W-1:0] burst_bytes = 8 * `FETCH_BURST_LEN;
  localparam logic [`FETCH_CNT_W-1:0]  burst_rows  = `FETCH_BURST_LEN;
  localparam logic [7:0]               burst_beats = `FETCH_BURST_LEN;

  typedef enum logic [1:0] {
    st_idle    = 2'b00,
    st_request = 2'b01,
    st_data    = 2'b10,
    st_drain   = 2'b11
  } state_t;

  state_t                   state;
  state_t                   state_d;
  logic [`FETCH_ADDR_W-1:0] ar_addr;
  logic [`FETCH_ADDR_W-1:0] next_addr;
  logic [`FETCH_ADDR_W-1:0] redirect_base;
  logic [`FETCH_ADDR_W-1:0] target;
  logic [7:0]               beats_left;
  logic                     stale;
  logic                     active;
  logic                     beat;
  logic                     last_beat;
  logic                     issue;

  assign redirect_base = {redirect_pc[`FETCH_ADDR_W-1:3], 3'b000};
  assign target        = redirect ? redirect_base : next_addr;

  // no reads before the first redirect
  assign rready    = !full && active;
  assign beat      = r.rvalid && rready;
  assign last_beat = beat && (r.rlast || beats_left == 8'd1);

  // --------------------------------------------------
  // bus and fifo outputs
  assign ar.araddr  = ar_addr;
  assign ar.arlen   = burst_beats - 8'd1;
  assign ar.arsize  = 3'd3;
  assign ar.arburst = fetch_pkg::burst_incr;
  assign ar.arvalid = (state == st_request);

  assign fifo_din.dword = r.rdata;
  assign fifo_wr        = beat && (state == st_data) && !redirect;
  assign fifo_clear     = redirect;

  always_comb begin
    state_d = state;
    issue   = 1'b0;
    case (state)
      st_idle: begin
        issue = redirect || (active && free_rows >= burst_rows);
      end
      st_request: begin
        if (arready) begin
          state_d = (stale || redirect) ? st_drain : st_data;
        end
      end
      st_data: begin
        if (last_beat) begin
          // this beat still takes a row
          issue   = redirect || (free_rows > burst_rows);
          state_d = st_idle;
        end else if (redirect) begin
          state_d = st_drain;
        end
      end
      default: begin
        issue = last_beat;
      end
    endcase
    if (issue) begin
      state_d = st_request;
    end
  end

  // --------------------------------------------------
  // state, addresses and beat count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      ar_addr    <= '0;
      next_addr  <= '0;
      beats_left <= '0;
      stale      <= 1'b0;
      active     <= 1'b0;
    end else begin
      state  <= state_d;
      active <= active || redirect;
      // request already on the bus cannot be withdrawn
      stale  <= (state == st_request) && !arready && (stale || redirect);
      if (issue) begin
        ar_addr   <= target;
        next_addr <= target + burst_bytes;
      end else if (redirect) begin
        next_addr <= redirect_base;
      end
      if (ar.arvalid && arready) begin
        beats_left <= burst_beats;
      end else if (beat && beats_left != '0) begin
        beats_left <= beats_left - 8'd1;
      end
    end
  end

endmodule

// ==== instr_align.sv ====
// instruction aligner
// cuts FIFO rows into parcels and builds 16-bit and 32-bit instructions with pc

`timescale 1ns/1ps
`include "fetch_config.svh"

module instr_align (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect,
  input  logic [`FETCH_ADDR_W-1:0]     redirect_pc,
  output logic                         fifo_rd,
  input  fetch_pkg::fetch_row_u        fifo_dout,
  input  logic                         fifo_empty,
  input  logic                         instr_take,
  output logic                         instr_valid,
  output fetch_pkg::instr_out_t        instr
);

  fetch_pkg::fetch_row_u    row_q;
  logic                     row_ok;
  logic [1:0]               idx;
  logic [15:0]              carry;
  logic                     carry_ok;
  logic [`FETCH_ADDR_W-1:0] pc_q;
  logic [`FETCH_ADDR_W-1:0] pc_next;

  logic [15:0] cur;
  logic [15:0] nxt;
  logic [31:0] word;
  logic        valid;
  logic        comp;
  logic        last;
  logic        span;
  logic        take;
  logic        row_done;
  logic        carry_after;

  // --------------------------------------------------
  // decode the parcel at idx
  always_comb begin
    cur   = row_q.parcel[idx];
    nxt   = row_q.parcel[idx + 2'd1];
    valid = 1'b0;
    word  = `FETCH_NOP;
    comp  = 1'b0;
    last  = 1'b0;
    span  = 1'b0;
    if (row_ok) begin
      if (carry_ok) begin
        valid = 1'b1;
        word  = {cur, carry};
      end else if (cur[1:0] != 2'b11) begin
        valid = 1'b1;
        word  = {16'h0000, cur};
        comp  = 1'b1;
        last  = (idx == 2'd3);
      end else if (idx != 2'd3) begin
        valid = 1'b1;
        word  = {nxt, cur};
        last  = (idx == 2'd2);
      end else begin
        // upper half lives in the next row
        span = 1'b1;
      end
    end
  end

  assign take        = instr_take && valid;
  assign row_done    = span || (take && last);
  assign carry_after = span || (carry_ok && !take);
  assign pc_next     = take ? pc_q + (comp ? 32'd2 : 32'd4) : pc_q;
  assign fifo_rd     = (!row_ok || row_done) && !fifo_empty && !redirect;

  assign instr_valid      = valid;
  assign instr.instr      = word;
  assign instr.pc         = pc_q;
  assign instr.compressed = comp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_ok   <= 1'b0;
      carry_ok <= 1'b0;
      idx      <= '0;
      pc_q     <= '0;
    end else if (redirect) begin
      row_ok   <= 1'b0;
      carry_ok <= 1'b0;
      pc_q     <= {redirect_pc[`FETCH_ADDR_W-1:1], 1'b0};
    end else begin
      pc_q     <= pc_next;
      carry_ok <= carry_after;
      if (fifo_rd) begin
        row_ok <= 1'b1;
        // first row after a redirect starts at pc bits [2:1]
        idx    <= carry_after ? 2'd0 : pc_next[2:1];
      end else if (row_done) begin
        row_ok <= 1'b0;
      end else if (take) begin
        idx <= idx + ((carry_ok || comp) ? 2'd1 : 2'd2);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_rd) begin
      row_q <= fifo_dout;
    end
    if (span) begin
      carry <= cur;
    end
  end

endmodule

// ==== fetch_unit.sv ====
// instruction fetch front end
// AXI read master, row FIFO and parcel aligner

`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         redirect,
  input  logic [`FETCH_ADDR_W-1:0]     redirect_pc,
  output fetch_pkg::axi_ar_t           ar,
  input  logic                         arready,
  input  fetch_pkg::axi_r_t            r,
  output logic                         rready,
  input  logic                         instr_take,
  output logic                         instr_valid,
  output fetch_pkg::instr_out_t        instr,
  output logic [`FETCH_ID_W-1:0]       arid,
  output logic                         arlock,
  output logic [3:0]                   arcache,
  output logic [2:0]                   arprot,
  output logic [3:0]                   arqos,
  output logic [3:0]                   arregion
);

  logic                    fifo_wr;
  logic                    fifo_rd;
  logic                    fifo_clear;
  logic                    fifo_full;
  logic                    fifo_empty;
  logic [`FETCH_CNT_W-1:0] free_rows;
  fetch_pkg::fetch_row_u   fifo_din;
  fetch_pkg::fetch_row_u   fifo_dout;

  // single id, plain normal access
  assign arid     = '0;
  assign arlock   = 1'b0;
  assign arcache  = '0;
  assign arprot   = '0;
  assign arqos    = '0;
  assign arregion = '0;

  ifu_mem_ctrl u_mem_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ar          (ar),
    .arready     (arready),
    .r           (r),
    .rready      (rready),
    .fifo_wr     (fifo_wr),
    .fifo_din    (fifo_din),
    .fifo_clear  (fifo_clear),
    .free_rows   (free_rows),
    .full        (fifo_full)
  );

  fetch_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (fifo_clear),
    .wr_en     (fifo_wr),
    .din       (fifo_din),
    .rd_en     (fifo_rd),
    .dout      (fifo_dout),
    .full      (fifo_full),
    .empty     (fifo_empty),
    .free_rows (free_rows)
  );

  instr_align u_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fifo_rd     (fifo_rd),
    .fifo_dout   (fifo_dout),
    .fifo_empty  (fifo_empty),
    .instr_take  (instr_take),
    .instr_valid (instr_valid),
    .instr       (instr)
  );

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock and reset
// 10 ns clock, active low reset held for a fixed number of cycles

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #5 clk = ~clk;

endmodule

// ==== tb_fetch_unit.sv ====
// fetch unit testbench
// AXI memory model, redirect and take stimulus, checks against the golden stream

`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_fetch_unit;

  logic clk;
  logic rst_n;
  logic redirect;
  logic [31:0] redirect_pc;
  logic arready;
  logic rready;
  logic instr_take;
  logic instr_valid;
  fetch_pkg::axi_ar_t ar;
  fetch_pkg::axi_r_t r;
  fetch_pkg::instr_out_t instr;
  logic [`FETCH_ID_W-1:0] arid;
  logic arlock;
  logic [3:0] arcache;
  logic [2:0] arprot;
  logic [3:0] arqos;
  logic [3:0] arregion;

  integer seed = 55640;
  integer cycles = 0;
  integer timeout_limit = 100000;
  integer owed = 0;
  integer error_count = 0;
  integer beat_idx = 0;
  integer gap = 0;
  bit beat_taken = 0;
  bit rv_cur = 0;
  logic [31:0] last_addr = 32'hffff_ffe0;
  logic [31:0] last_base = 32'h0;

  logic [63:0] mem_img [logic [31:0]];
  logic [31:0] bursts [$];
  logic [31:0] got_pc [$];
  logic [31:0] got_word [$];
  logic got_comp [$];
  byte cmd_kind [$];
  logic [31:0] cmd_a [$];
  logic [31:0] cmd_b [$];
  logic cmd_c [$];

  tb_clk_gen #(.reset_cycles(10)) u_clk_gen (.clk(clk), .rst_n(rst_n));

  fetch_unit DUT (
    .clk(clk), .rst_n(rst_n), .redirect(redirect), .redirect_pc(redirect_pc),
    .ar(ar), .arready(arready), .r(r), .rready(rready), .instr_take(instr_take),
    .instr_valid(instr_valid), .instr(instr), .arid(arid), .arlock(arlock),
    .arcache(arcache), .arprot(arprot), .arqos(arqos), .arregion(arregion)
  );

  // unloaded addresses read back a pattern of the whole address
  function automatic logic [63:0] read_mem(input logic [31:0] addr);
    if (mem_img.exists(addr)) begin
      return mem_img[addr];
    end
    return {~addr, addr};
  endfunction

  task automatic load_golden();
    integer fd;
    integer n;
    string line;
    string tag;
    logic [31:0] a;
    logic [63:0] d;
    integer c;
    fd = $fopen("fetch_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open the golden file fetch_golden.txt");
      $display("tests failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s", tag);
      if (n == 1 && tag == "M") begin
        n = $sscanf(line, "M %h %h", a, d);
        mem_img[a] = d;
      end else if (n == 1 && (tag == "R" || tag == "E")) begin
        c = 0;
        d = '0;
        if (tag == "R") begin
          n = $sscanf(line, "R %h", a);
        end else begin
          n = $sscanf(line, "E %h %h %d", a, d, c);
        end
        cmd_kind.push_back(tag == "R" ? 8'd82 : 8'd69);
        cmd_a.push_back(a);
        cmd_b.push_back(d[31:0]);
        cmd_c.push_back(c[0]);
      end
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // --------------------------------------------------
  // observe handshakes where the outputs are stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (ar.arvalid && arready) begin
        check_value("ar.arburst", {30'd0, ar.arburst}, 32'd1);
        check_value("ar.arlen", {24'd0, ar.arlen}, `FETCH_BURST_LEN - 1);
        // 8-byte beats
        check_value("ar.arsize", {29'd0, ar.arsize}, 32'd3);
        check_value("ar.araddr[2:0]", {29'd0, ar.araddr[2:0]}, 32'd0);
        check_value("arid", 32'(arid), 32'd0);
        check_value("arlock", {31'd0, arlock}, 32'd0);
        check_value("arcache", {28'd0, arcache}, 32'd0);
        check_value("arprot", {29'd0, arprot}, 32'd0);
        check_value("arqos", {28'd0, arqos}, 32'd0);
        check_value("arregion", {28'd0, arregion}, 32'd0);
        assert (ar.araddr == last_addr + 8 * `FETCH_BURST_LEN || ar.araddr == last_base)
        else begin
          error_count++;
          $display("burst address %h is neither sequential nor a redirect target",
                   ar.araddr);
          $display("tests failed");
          $fatal(1);
        end
        last_addr = ar.araddr;
        bursts.push_back(ar.araddr);
      end
      if (r.rvalid && rready) begin
        beat_taken = 1;
      end
      if (!instr_valid) begin
        // idle output shows a nop
        check_value("instr.instr", instr.instr, `FETCH_NOP);
        check_value("instr.compressed", {31'd0, instr.compressed}, 32'd0);
      end
      if (instr_take && instr_valid) begin
        got_pc.push_back(instr.pc);
        got_word.push_back(instr.instr);
        got_comp.push_back(instr.compressed);
        owed--;
      end
    end
  end

  // --------------------------------------------------
  // memory model and take driver
  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("fetch stalled: no progress within %0d cycles", timeout_limit);
      $display("tests failed");
      $fatal(1);
    end
    if (rst_n) begin
      arready <= ($random(seed) & 3) != 0;
      // stall windows let the FIFO fill and back-pressure the bus
      instr_take <= (owed > 0) && (cycles[6:5] != 2'b11) && ($random(seed) & 1);
      if (beat_taken) begin
        beat_taken = 0;
        rv_cur = 0;
        beat_idx++;
        if (beat_idx == `FETCH_BURST_LEN) begin
          beat_idx = 0;
          void'(bursts.pop_front());
        end
      end
      if (!rv_cur && bursts.size() > 0 && gap == 0) begin
        r <= fetch_pkg::axi_r_t'{rdata: read_mem(bursts[0] + 8 * beat_idx), rresp: 2'b00,
                                 rlast: (beat_idx == `FETCH_BURST_LEN - 1), rvalid: 1'b1};
        rv_cur = 1;
        gap = $random(seed) & 3;
      end else if (!rv_cur) begin
        r <= '0;
        if (gap > 0) begin
          gap--;
        end
      end
    end
  end

  initial begin
    integer i;
    integer j;
    integer n_e;
    redirect    = 1'b0;
    redirect_pc = '0;
    arready     = 1'b0;
    instr_take  = 1'b0;
    r           = '0;
    load_golden();
    n_e = 0;
    foreach (cmd_kind[k]) begin
      if (cmd_kind[k] == 8'd69) begin
        n_e++;
      end
    end
    timeout_limit = 60 * n_e + 500;
    @(posedge rst_n);
    @(posedge clk);
    // quiet outputs out of reset
    @(negedge clk);
    check_value("ar.arvalid", {31'd0, ar.arvalid}, 32'd0);
    check_value("rready", {31'd0, rready}, 32'd0);
    check_value("instr_valid", {31'd0, instr_valid}, 32'd0);
    i = 0;
    while (i < cmd_kind.size()) begin
      if (cmd_kind[i] == 8'd82) begin
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= cmd_a[i];
        last_base = {cmd_a[i][31:3], 3'b000};
        @(posedge clk);
        redirect <= 1'b0;
        i++;
      end else begin
        j = i;
        while (j < cmd_kind.size() && cmd_kind[j] == 8'd69) begin
          j++;
        end
        @(negedge clk);
        owed += j - i;
        for (; i < j; i++) begin
          while (got_pc.size() == 0) begin
            @(posedge clk);
          end
          check_value("instr.pc", got_pc.pop_front(), cmd_a[i]);
          check_value("instr.instr", got_word.pop_front(), cmd_b[i]);
          check_value("instr.compressed", {31'd0, got_comp.pop_front()}, {31'd0, cmd_c[i]});
        end
      end
    end
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== fetch_golden.txt ====
# M <row address> <64-bit row, lowest address in the low half>
# R <redirect pc>    E <pc> <instr> <compressed>
M 00001000 00A0019300500113
M 00001008 003100B300208233
M 00001010 0040006F40110133
M 00002000 859300B505334505
M 00002008 00018082050500C5
M 00002010 4601458100000013
M 00003000 4685FFFFFFFFFFFF
M 00003008 4781470100D60633
# straight 32-bit run
R 00001000
E 00001000 00500113 0
E 00001004 00A00193 0
E 00001008 00208233 0
E 0000100C 003100B3 0
E 00001010 40110133 0
E 00001014 0040006F 0
# mixed stream with a row-spanning instruction
R 00002000
E 00002000 00004505 1
E 00002002 00B50533 0
E 00002006 00C58593 0
E 0000200A 00000505 1
E 0000200C 00008082 1
E 0000200E 00000001 1
E 00002010 00000013 0
E 00002014 00004581 1
E 00002016 00004601 1
# unaligned redirects
R 00003006
E 00003006 00004685 1
E 00003008 00D60633 0
E 0000300C 00004701 1
E 0000300E 00004781 1
R 00002006
E 00002006 00C58593 0
E 0000200A 00000505 1
R 00001008
E 00001008 00208233 0
E 0000100C 003100B3 0
E 00001010 40110133 0
E 00001014 0040006F 0

// ==== fetch_unit.f ====
+incdir+.
fetch_pkg.sv
fetch_fifo.sv
ifu_mem_ctrl.sv
instr_align.sv
fetch_unit.sv
tb_clk_gen.sv
tb_fetch_unit.sv

// ==== Makefile ====
TOP = tb_fetch_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f fetch_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing -f fetch_unit.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
